//--- src.f
rtl/ReplayPkg.sv
rtl/ReplayStorage.sv
rtl/ReplayIntervalTimer.sv
rtl/ReplayFlushTracker.sv
rtl/ReplayPopControl.sv
rtl/ReplayQueue.sv
verification/ReplayQueueChecker.sv
verification/ReplayQueueTb.sv

//--- Makefile
TOP = ReplayQueueTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv --top-module $(TOP) -f src.f -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- verification/ReplayQueueTb.sv
// Replay queue testbench
// Applies a table of record groups, MSHR changes and recoveries to the DUT,
// with LFSR payloads, and reports the checker's findings per test
`default_nettype none

module ReplayQueueTb import ReplayPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        int           test;
        int           gap;
        logic [1:0]   iv;
        ActiveListPtr p0;
        ActiveListPtr p1;
        logic         mv;
        ActiveListPtr mp;
        logic         ld;
        logic         hm;
        MshrId        mi;
        logic [3:0]   mV;
        logic [3:0]   mF;
        logic         rec;
        logic         fa;
        ActiveListPtr fh;
        ActiveListPtr ft;
    } Row;

    logic                clk;
    logic                rstN;
    logic         [1:0]  intRecValid;
    ActiveListPtr [1:0]  intRecPtr;
    OpPayload     [1:0]  intRecData;
    logic                memRecValid;
    ActiveListPtr        memRecPtr;
    OpPayload            memRecData;
    logic                memRecIsLoad;
    logic                memRecHasMshr;
    MshrId               memRecMshrId;
    logic         [3:0]  mshrValid;
    logic         [3:0]  mshrFilled;
    logic                toRecovery;
    ActiveListPtr        flushHead;
    ActiveListPtr        flushTail;
    logic                flushAll;
    logic         [1:0]  intRepValid;
    ActiveListPtr [1:0]  intRepPtr;
    OpPayload     [1:0]  intRepData;
    logic                memRepValid;
    ActiveListPtr        memRepPtr;
    OpPayload            memRepData;
    logic                memRepIsLoad;
    logic                memRepHasMshr;
    MshrId               memRepMshrId;
    logic                replay;
    logic                stall;
    logic                flushedOpExist;

    Row          rows[$];
    string       testNames[5] = '{"order", "spacing", "mshr wait", "flush", "stall"};
    logic [31:0] lfsr = 32'd99043;
    int          cycles = 0;
    int          limit = 100000;
    int          errStart;

    ReplayQueue dut0 (.*);

    ReplayQueueChecker chk0 (.*);

    // Galois LFSR stepped once per payload bit
    function automatic OpPayload nextPayload();
        OpPayload bits;
        logic     lsb;
        bits = '0;
        for (int i = 0; i < 16; i++) begin
            lsb = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 32'h80200003;
            end
            bits = {bits[14:0], lsb};
        end
        return bits;
    endfunction

    // rec is 0 for no recovery, 1 for the given range and 2 for a full flush
    task automatic addRow(input int test, input int gap, input int iv, input int p0,
                          input int p1, input int mv, input int mp, input int ld,
                          input int hm, input int mi, input int mV, input int mF,
                          input int rec, input int fh, input int ft);
        Row r;
        r = '{test, gap, 2'(iv), 5'(p0), 5'(p1), 1'(mv), 5'(mp), 1'(ld), 1'(hm),
              2'(mi), 4'(mV), 4'(mF), 1'(rec != 0), 1'(rec == 2),
              5'(fh), 5'(ft)};
        rows.push_back(r);
    endtask

    // MSHR state is left as the last row set it
    task automatic driveIdle();
        intRecValid = '0;
        intRecPtr = '0;
        intRecData = '0;
        memRecValid = 1'b0;
        memRecPtr = '0;
        memRecData = '0;
        memRecIsLoad = 1'b0;
        memRecHasMshr = 1'b0;
        memRecMshrId = '0;
        toRecovery = 1'b0;
        flushHead = '0;
        flushTail = '0;
        flushAll = 1'b0;
    endtask

    task automatic applyRow(input Row r);
        repeat (r.gap) begin
            @(posedge clk);
            #2;
            driveIdle();
        end
        @(posedge clk);
        #2;
        intRecValid = r.iv;
        intRecPtr = {r.p1, r.p0};
        intRecData = {nextPayload(), nextPayload()};
        memRecValid = r.mv;
        memRecPtr = r.mp;
        memRecData = nextPayload();
        memRecIsLoad = r.ld;
        memRecHasMshr = r.hm;
        memRecMshrId = r.mi;
        mshrValid = r.mV;
        mshrFilled = r.mF;
        toRecovery = r.rec;
        flushAll = r.fa;
        flushHead = r.fh;
        flushTail = r.ft;
    endtask

    // Wait until the model queue is empty and the last replay was checked
    task automatic drainQueue();
        do begin
            @(posedge clk);
        end while (chk0.depth != 0 || chk0.expRep);
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic buildTable();
        addRow(0, 0, 3, 1, 2, 1, 3, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow(0, 1, 1, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow(0, 2, 0, 0, 0, 1, 5, 1, 0, 0, 0, 0, 0, 0, 0);
        addRow(1, 0, 1, 6, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow(1, 1, 2, 0, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow(1, 2, 1, 8, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow(1, 5, 3, 9, 10, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // Load on MSHR 1 holds back the groups queued behind it
        addRow(2, 0, 0, 0, 0, 1, 14, 1, 1, 1, 'b0010, 0, 0, 0, 0);
        addRow(2, 0, 1, 15, 0, 0, 0, 0, 0, 0, 'b0010, 0, 0, 0, 0);
        addRow(2, 0, 0, 0, 0, 1, 16, 1, 0, 2, 'b0110, 0, 0, 0, 0);
        addRow(2, 3, 0, 0, 0, 0, 0, 0, 0, 0, 'b0110, 'b0010, 0, 0, 0);
        // Blocked head outside a wrapping range with flushed groups behind it
        addRow(3, 0, 0, 0, 0, 1, 25, 1, 1, 0, 'b0001, 0, 0, 0, 0);
        addRow(3, 0, 3, 10, 11, 0, 0, 0, 0, 0, 'b0001, 0, 0, 0, 0);
        addRow(3, 0, 1, 12, 0, 0, 0, 0, 0, 0, 'b0001, 0, 0, 0, 0);
        addRow(3, 0, 3, 20, 21, 0, 0, 0, 0, 0, 'b0001, 0, 0, 0, 0);
        addRow(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 'b0001, 0, 1, 30, 13);
        addRow(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 'b0001, 'b0001, 0, 0, 0);
        // A full flush lets a blocked load leave the head without a replay
        addRow(3, 0, 1, 22, 0, 1, 24, 1, 1, 0, 'b0001, 0, 0, 0, 0);
        addRow(3, 5, 0, 0, 0, 0, 0, 0, 0, 0, 'b0001, 0, 2, 0, 0);
        // Recovery on an empty queue ends tracking
        addRow(4, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        addRow(4, 0, 0, 0, 0, 1, 14, 1, 1, 3, 'b1000, 0, 0, 0, 0);
        for (int i = 0; i < 8; i++) begin
            addRow(4, 0, 1, 16 + i, 0, 0, 0, 0, 0, 0, 'b1000, 0, 0, 0, 0);
        end
        addRow(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 'b1000, 'b1000, 0, 0, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        mshrValid = '0;
        mshrFilled = '0;
        driveIdle();
        buildTable();
        limit = rows.size() * 8 + 50;
        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int t = 0; t < 5; t++) begin
            errStart = chk0.errors;
            foreach (rows[r]) begin
                if (rows[r].test == t) begin
                    applyRow(rows[r]);
                end
            end
            @(posedge clk);
            #2;
            driveIdle();
            drainQueue();
            $display("test %0d %s: %0d errors", t, testNames[t], chk0.errors - errStart);
        end
        $display("checks %0d, errors %0d", chk0.checks, chk0.errors);
        if (chk0.errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/ReplayQueueChecker.sv
// Replay queue checker
// Reference model of the queue built from the record, pop and flush rules,
// compared against the DUT outputs at every falling clock edge
`default_nettype none

module ReplayQueueChecker import ReplayPkg::*; (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic         [1:0]  intRecValid,
    input  wire ActiveListPtr [1:0]  intRecPtr,
    input  wire OpPayload     [1:0]  intRecData,
    input  wire logic                memRecValid,
    input  wire ActiveListPtr        memRecPtr,
    input  wire OpPayload            memRecData,
    input  wire logic                memRecIsLoad,
    input  wire logic                memRecHasMshr,
    input  wire MshrId               memRecMshrId,
    input  wire logic         [3:0]  mshrValid,
    input  wire logic         [3:0]  mshrFilled,
    input  wire logic                toRecovery,
    input  wire ActiveListPtr        flushHead,
    input  wire ActiveListPtr        flushTail,
    input  wire logic                flushAll,
    input  wire logic         [1:0]  intRepValid,
    input  wire ActiveListPtr [1:0]  intRepPtr,
    input  wire OpPayload     [1:0]  intRepData,
    input  wire logic                memRepValid,
    input  wire ActiveListPtr        memRepPtr,
    input  wire OpPayload            memRepData,
    input  wire logic                memRepIsLoad,
    input  wire logic                memRepHasMshr,
    input  wire MshrId               memRepMshrId,
    input  wire logic                replay,
    input  wire logic                stall,
    input  wire logic                flushedOpExist
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic         [1:0] iv;
        ActiveListPtr [1:0] ip;
        OpPayload     [1:0] id;
        logic               mv;
        ActiveListPtr       mp;
        OpPayload           md;
        logic               ld;
        logic               hm;
        MshrId              mi;
        ReplayInterval      gap;
    } Group;

    Group         q[$];
    Group         expGroup;
    logic   [1:0] expIv;
    logic         expMv;
    logic         expRep;
    int           pushTimer;
    int           popTimer;
    int           stale;
    logic         tracking;
    ActiveListPtr heldHead;
    ActiveListPtr heldTail;
    logic         heldAll;
    int           depth;
    int           errors;
    int           checks;

    // Circular half-open range test by offset from the range head
    function automatic logic inRange(input ActiveListPtr p, input ActiveListPtr h,
                                     input ActiveListPtr t, input logic all);
        ActiveListPtr off;
        ActiveListPtr len;
        off = p - h;
        len = t - h;
        return all || (off < len);
    endfunction

    function automatic logic isFlushed(input ActiveListPtr p);
        return (toRecovery && inRange(p, flushHead, flushTail, flushAll))
            || (tracking && inRange(p, heldHead, heldTail, heldAll));
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareOutputs();
        checkValue("replay", 32'(replay), 32'(expRep));
        checkValue("stall", 32'(stall), 32'(expRep || q.size() >= 6));
        checkValue("flushedOpExist", 32'(flushedOpExist), 32'(tracking));
        checkValue("intRepValid", 32'(intRepValid), 32'(expIv));
        checkValue("memRepValid", 32'(memRepValid), 32'(expMv));
        for (int i = 0; i < 2; i++) begin
            if (expIv[i]) begin
                checkValue($sformatf("intRepPtr[%0d]", i), 32'(intRepPtr[i]),
                           32'(expGroup.ip[i]));
                checkValue($sformatf("intRepData[%0d]", i), 32'(intRepData[i]),
                           32'(expGroup.id[i]));
            end
        end
        if (expMv) begin
            checkValue("memRepPtr", 32'(memRepPtr), 32'(expGroup.mp));
            checkValue("memRepData", 32'(memRepData), 32'(expGroup.md));
            checkValue("memRepIsLoad", 32'(memRepIsLoad), 32'(expGroup.ld));
            checkValue("memRepHasMshr", 32'(memRepHasMshr), 32'(expGroup.hm));
            checkValue("memRepMshrId", 32'(memRepMshrId), 32'(expGroup.mi));
        end
    endtask

    // One model step covers what the next rising edge does
    task automatic stepModel();
        Group       h;
        Group       g;
        logic [1:0] fI;
        logic       fM;
        logic       popNow;
        logic       pushNow;
        h = '0;
        fI = '0;
        fM = 1'b0;
        popNow = 1'b0;
        if (q.size() > 0) begin
            h = q[0];
            for (int i = 0; i < 2; i++) begin
                fI[i] = isFlushed(h.ip[i]);
            end
            fM = isFlushed(h.mp);
            popNow = (popTimer >= int'(h.gap))
                && !(h.mv && !fM && h.ld && h.hm && mshrValid[h.mi] && !mshrFilled[h.mi]);
        end
        pushNow = ((|intRecValid) || memRecValid) && q.size() < 8;

        // Tracker sees the replay pulse currently on the outputs
        if (toRecovery) begin
            stale = q.size();
            tracking = (stale != 0);
            heldHead = flushHead;
            heldTail = flushTail;
            heldAll = flushAll;
        end else if (tracking && expRep) begin
            stale--;
            if (stale == 0) begin
                tracking = 1'b0;
            end
        end

        expGroup = h;
        expIv = popNow ? (h.iv & ~fI) : 2'b00;
        expMv = popNow && h.mv && !fM;
        expRep = (|expIv) || expMv;

        g = '{intRecValid, intRecPtr, intRecData, memRecValid, memRecPtr, memRecData,
              memRecIsLoad, memRecHasMshr, memRecMshrId, ReplayInterval'(pushTimer)};
        pushTimer = pushNow ? 0 : (pushTimer < 3 ? pushTimer + 1 : 3);
        popTimer = popNow ? 0 : (popTimer < 3 ? popTimer + 1 : 3);
        if (popNow) begin
            void'(q.pop_front());
        end
        if (pushNow) begin
            q.push_back(g);
        end
        depth = q.size();
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(negedge clk) begin
        if (!rstN) begin
            q.delete();
            expGroup = '0;
            expIv = '0;
            expMv = 1'b0;
            expRep = 1'b0;
            pushTimer = 0;
            popTimer = 0;
            stale = 0;
            tracking = 1'b0;
            heldHead = '0;
            heldTail = '0;
            heldAll = 1'b0;
            depth = 0;
        end else begin
            compareOutputs();
            stepModel();
        end
    end

endmodule

`default_nettype wire

//--- rtl/ReplayQueue.sv
// Replay queue top level
// Records issue groups with their spacing and replays them in order,
// holding the head on pending load misses and masking flushed lanes
`default_nettype none

module ReplayQueue import ReplayPkg::*; #(
    parameter int QueueDepth  = 8,
    parameter int IntLanes    = 2,
    parameter int MemLatency  = 2,
    parameter int MaxInterval = 3,
    parameter int MshrNum     = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    // Record side
    input  logic         [IntLanes-1:0]  intRecValid,
    input  ActiveListPtr [IntLanes-1:0]  intRecPtr,
    input  OpPayload     [IntLanes-1:0]  intRecData,
    input  logic                         memRecValid,
    input  ActiveListPtr                 memRecPtr,
    input  OpPayload                     memRecData,
    input  logic                         memRecIsLoad,
    input  logic                         memRecHasMshr,
    input  MshrId                        memRecMshrId,
    // MSHR state
    input  logic         [MshrNum-1:0]   mshrValid,
    input  logic         [MshrNum-1:0]   mshrFilled,
    // Recovery
    input  logic                         toRecovery,
    input  ActiveListPtr                 flushHead,
    input  ActiveListPtr                 flushTail,
    input  logic                         flushAll,
    // Replay side
    output logic         [IntLanes-1:0]  intRepValid,
    output ActiveListPtr [IntLanes-1:0]  intRepPtr,
    output OpPayload     [IntLanes-1:0]  intRepData,
    output logic                         memRepValid,
    output ActiveListPtr                 memRepPtr,
    output OpPayload                     memRepData,
    output logic                         memRepIsLoad,
    output logic                         memRepHasMshr,
    output MshrId                        memRepMshrId,
    output logic                         replay,
    output logic                         stall,
    output logic                         flushedOpExist
);

    logic                        push;
    logic                        pop;
    logic                        empty;
    logic                        almostFull;
    QueueCount                   count;
    ReplayInterval               pushGap;
    ReplayInterval               popGap;
    ReplayInterval               recInterval;

    // Head entry as read from storage
    logic         [IntLanes-1:0] headIntValid;
    ActiveListPtr [IntLanes-1:0] headIntPtr;
    OpPayload     [IntLanes-1:0] headIntData;
    logic                        headMemValid;
    ActiveListPtr                headMemPtr;
    OpPayload                    headMemData;
    logic                        headMemIsLoad;
    logic                        headMemHasMshr;
    MshrId                       headMemMshrId;
    ReplayInterval               headInterval;

    // Range held while stale entries may remain
    logic                        tracking;
    ActiveListPtr                heldHead;
    ActiveListPtr                heldTail;
    logic                        heldAll;

    // Each group is stamped with the gap since the previous push
    assign recInterval = pushGap;

    ReplayStorage #(
        .QueueDepth (QueueDepth),
        .IntLanes   (IntLanes),
        .MemLatency (MemLatency)
    ) storage0 (.*);

    ReplayIntervalTimer #(
        .MaxInterval (MaxInterval)
    ) timer0 (.*);

    ReplayFlushTracker flushTracker0 (.*);

    ReplayPopControl #(
        .IntLanes (IntLanes),
        .MshrNum  (MshrNum)
    ) popControl0 (.*);

    // Hold off the issue stage while replaying or close to full
    assign stall = replay | almostFull;

endmodule

`default_nettype wire

//--- rtl/ReplayPopControl.sv
// Replay pop control
// Decides when the head group leaves, masks flushed lanes and
// registers the replayed group onto the outputs
`default_nettype none

module ReplayPopControl import ReplayPkg::*; #(
    parameter int IntLanes = 2,
    parameter int MshrNum  = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic         [IntLanes-1:0]  headIntValid,
    input  ActiveListPtr [IntLanes-1:0]  headIntPtr,
    input  OpPayload     [IntLanes-1:0]  headIntData,
    input  logic                         headMemValid,
    input  ActiveListPtr                 headMemPtr,
    input  OpPayload                     headMemData,
    input  logic                         headMemIsLoad,
    input  logic                         headMemHasMshr,
    input  MshrId                        headMemMshrId,
    input  ReplayInterval                headInterval,
    input  logic                         empty,
    input  ReplayInterval                popGap,
    input  logic         [MshrNum-1:0]   mshrValid,
    input  logic         [MshrNum-1:0]   mshrFilled,
    input  logic                         toRecovery,
    input  ActiveListPtr                 flushHead,
    input  ActiveListPtr                 flushTail,
    input  logic                         flushAll,
    input  logic                         tracking,
    input  ActiveListPtr                 heldHead,
    input  ActiveListPtr                 heldTail,
    input  logic                         heldAll,
    output logic                         pop,
    output logic                         replay,
    output logic         [IntLanes-1:0]  intRepValid,
    output ActiveListPtr [IntLanes-1:0]  intRepPtr,
    output OpPayload     [IntLanes-1:0]  intRepData,
    output logic                         memRepValid,
    output ActiveListPtr                 memRepPtr,
    output OpPayload                     memRepData,
    output logic                         memRepIsLoad,
    output logic                         memRepHasMshr,
    output MshrId                        memRepMshrId
);

    logic [IntLanes-1:0] intFlush;
    logic                memFlush;
    logic                memWait;
    logic [IntLanes-1:0] nextIntValid;
    logic                nextMemValid;

    // Half-open circular range [head, tail), or everything
    function automatic logic flushMatch(
        input logic         active,
        input ActiveListPtr head,
        input ActiveListPtr tail,
        input logic         all,
        input ActiveListPtr ptr
    );
        logic inRange;
        if (head <= tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else begin
            inRange = (ptr >= head) || (ptr < tail);
        end
        return active && (all || inRange);
    endfunction

    // The live range covers this cycle, the held one covers older entries
    always_comb begin
        for (int i = 0; i < IntLanes; i++) begin
            intFlush[i] = flushMatch(toRecovery, flushHead, flushTail, flushAll, headIntPtr[i])
                || flushMatch(tracking, heldHead, heldTail, heldAll, headIntPtr[i]);
        end
        memFlush = flushMatch(toRecovery, flushHead, flushTail, flushAll, headMemPtr)
            || flushMatch(tracking, heldHead, heldTail, heldAll, headMemPtr);
    end

    // A live load still waiting on its miss blocks the whole group
    assign memWait = headMemValid && !memFlush && headMemIsLoad && headMemHasMshr
        && mshrValid[headMemMshrId] && !mshrFilled[headMemMshrId];

    assign pop = !empty && (popGap >= headInterval) && !memWait;

    assign nextIntValid = {IntLanes{pop}} & headIntValid & ~intFlush;
    assign nextMemValid = pop & headMemValid & ~memFlush;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            intRepValid <= '0;
            memRepValid <= 1'b0;
            replay      <= 1'b0;
        end else begin
            intRepValid <= nextIntValid;
            memRepValid <= nextMemValid;
            replay      <= (|nextIntValid) || nextMemValid;
        end
    end

    always_ff @(posedge clk) begin
        intRepPtr     <= headIntPtr;
        intRepData    <= headIntData;
        memRepPtr     <= headMemPtr;
        memRepData    <= headMemData;
        memRepIsLoad  <= headMemIsLoad;
        memRepHasMshr <= headMemHasMshr;
        memRepMshrId  <= headMemMshrId;
    end

    replayHasLane: assert property (@(posedge clk) disable iff (!rstN)
        replay |-> (|intRepValid) || memRepValid)
        else $error("replay raised with every lane invalid");

endmodule

`default_nettype wire

//--- rtl/ReplayFlushTracker.sv
// Flush range tracker
// Holds the last recovery range while entries recorded before it
// may still sit in the queue, counted down by replays
`default_nettype none

module ReplayFlushTracker import ReplayPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  logic         toRecovery,
    input  ActiveListPtr flushHead,
    input  ActiveListPtr flushTail,
    input  logic         flushAll,
    input  QueueCount    count,
    input  logic         replay,
    output logic         tracking,
    output ActiveListPtr heldHead,
    output ActiveListPtr heldTail,
    output logic         heldAll,
    output logic         flushedOpExist
);

    FlushState state;
    QueueCount staleCount;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= FlushIdle;
            staleCount <= '0;
        end else if (toRecovery) begin
            // Everything queued now may hold ops from the flushed range
            state      <= (count != '0) ? FlushTracking : FlushIdle;
            staleCount <= count;
        end else if (state == FlushTracking && replay) begin
            staleCount <= staleCount - 1'b1;
            if (staleCount == QueueCount'(1)) begin
                state <= FlushIdle;
            end
        end
    end

    // Range is only looked at while tracking
    always_ff @(posedge clk) begin
        if (toRecovery) begin
            heldHead <= flushHead;
            heldTail <= flushTail;
            heldAll  <= flushAll;
        end
    end

    assign tracking       = (state == FlushTracking);
    assign flushedOpExist = (state == FlushTracking);

    idleMeansNoStale: assert property (@(posedge clk) disable iff (!rstN)
        state == FlushIdle |-> staleCount == '0)
        else $error("stale entry count left over in idle");

endmodule

`default_nettype wire

//--- rtl/ReplayIntervalTimer.sv
// Replay interval timer
// Counts cycles since the last push and since the last pop, saturating
`default_nettype none

module ReplayIntervalTimer import ReplayPkg::*; #(
    parameter int MaxInterval = 3
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          push,
    input  logic          pop,
    output ReplayInterval pushGap,
    output ReplayInterval popGap
);

    function automatic ReplayInterval nextGap(input ReplayInterval gap, input logic clear);
        ReplayInterval result;
        if (clear) begin
            result = '0;
        end else if (gap < MaxInterval) begin
            result = ReplayInterval'(gap + 1'b1);
        end else begin
            result = gap;
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pushGap <= '0;
            popGap  <= '0;
        end else begin
            // pushGap is stamped on the next group, popGap gates the head
            pushGap <= nextGap(pushGap, push);
            popGap  <= nextGap(popGap, pop);
        end
    end

    gapSaturates: assert property (@(posedge clk) disable iff (!rstN)
        pushGap <= MaxInterval && popGap <= MaxInterval)
        else $error("interval counter ran past its limit");

endmodule

`default_nettype wire

//--- rtl/ReplayStorage.sv
// Replay queue entry storage
// Circular memory written at the tail and read at the head, with
// occupancy tracking
`default_nettype none

module ReplayStorage import ReplayPkg::*; #(
    parameter int QueueDepth = 8,
    parameter int IntLanes   = 2,
    parameter int MemLatency = 2
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic         [IntLanes-1:0]  intRecValid,
    input  ActiveListPtr [IntLanes-1:0]  intRecPtr,
    input  OpPayload     [IntLanes-1:0]  intRecData,
    input  logic                         memRecValid,
    input  ActiveListPtr                 memRecPtr,
    input  OpPayload                     memRecData,
    input  logic                         memRecIsLoad,
    input  logic                         memRecHasMshr,
    input  MshrId                        memRecMshrId,
    input  ReplayInterval                recInterval,
    input  logic                         pop,
    output logic                         push,
    output logic         [IntLanes-1:0]  headIntValid,
    output ActiveListPtr [IntLanes-1:0]  headIntPtr,
    output OpPayload     [IntLanes-1:0]  headIntData,
    output logic                         headMemValid,
    output ActiveListPtr                 headMemPtr,
    output OpPayload                     headMemData,
    output logic                         headMemIsLoad,
    output logic                         headMemHasMshr,
    output MshrId                        headMemMshrId,
    output ReplayInterval                headInterval,
    output logic                         empty,
    output logic                         almostFull,
    output QueueCount                    count
);

    logic         [IntLanes-1:0] intValidMem [QueueDepth];
    ActiveListPtr [IntLanes-1:0] intPtrMem   [QueueDepth];
    OpPayload     [IntLanes-1:0] intDataMem  [QueueDepth];
    logic                        memValidMem [QueueDepth];
    ActiveListPtr                memPtrMem   [QueueDepth];
    OpPayload                    memDataMem  [QueueDepth];
    logic                        memLoadMem  [QueueDepth];
    logic                        memHasMem   [QueueDepth];
    MshrId                       memIdMem    [QueueDepth];
    ReplayInterval               gapMem      [QueueDepth];

    QueuePtr               headPtr;
    QueuePtr               tailPtr;
    logic                  full;

    assign full       = (count == QueueDepth);
    assign empty      = (count == '0);
    assign almostFull = (count >= QueueDepth - MemLatency);

    // A group with no valid lane is dropped at the door
    assign push = ((|intRecValid) || memRecValid) && !full;

    always_ff @(posedge clk) begin
        if (push) begin
            intValidMem[tailPtr] <= intRecValid;
            intPtrMem[tailPtr]   <= intRecPtr;
            intDataMem[tailPtr]  <= intRecData;
            memValidMem[tailPtr] <= memRecValid;
            memPtrMem[tailPtr]   <= memRecPtr;
            memDataMem[tailPtr]  <= memRecData;
            memLoadMem[tailPtr]  <= memRecIsLoad;
            memHasMem[tailPtr]   <= memRecHasMshr;
            memIdMem[tailPtr]    <= memRecMshrId;
            gapMem[tailPtr]      <= recInterval;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr  <= '0;
            tailPtr  <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tailPtr <= (tailPtr == QueuePtr'(QueueDepth - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= (headPtr == QueuePtr'(QueueDepth - 1)) ? '0 : headPtr + 1'b1;
            end
            count    <= count + QueueCount'(push) - QueueCount'(pop);
        end
    end

    // Head read is combinational
    assign headIntValid   = intValidMem[headPtr];
    assign headIntPtr     = intPtrMem[headPtr];
    assign headIntData    = intDataMem[headPtr];
    assign headMemValid   = memValidMem[headPtr];
    assign headMemPtr     = memPtrMem[headPtr];
    assign headMemData    = memDataMem[headPtr];
    assign headMemIsLoad  = memLoadMem[headPtr];
    assign headMemHasMshr = memHasMem[headPtr];
    assign headMemMshrId  = memIdMem[headPtr];
    assign headInterval   = gapMem[headPtr];

    popOnlyWhenFilled: assert property (@(posedge clk) disable iff (!rstN)
        pop |-> !empty)
        else $error("pop requested on an empty replay queue");

    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        count <= QueueDepth)
        else $error("replay queue occupancy out of range");

endmodule

`default_nettype wire

//--- rtl/ReplayPkg.sv
// Replay queue shared definitions
// Widths of the lane fields, queue pointers and the flush tracking states
`default_nettype none

package ReplayPkg;

    // Active-list size sets the width of an op's active-list pointer
    parameter int ActiveListDepth = 32;

    // Index of an op in the active list
    typedef logic [$clog2(ActiveListDepth)-1:0] ActiveListPtr;

    // Opaque op data carried from record to replay
    typedef logic [15:0] OpPayload;

    // One of four MSHRs
    typedef logic [1:0] MshrId;

    // Cycles between two recorded groups, saturating
    typedef logic [1:0] ReplayInterval;

    // Head and tail index into the entry memory
    typedef logic [2:0] QueuePtr;

    // Occupancy, wide enough to hold a full queue
    typedef logic [3:0] QueueCount;

    // Flush range tracking after a recovery
    typedef enum logic {
        FlushIdle,
        FlushTracking
    } FlushState;

endpackage

`default_nettype wire
